/* sources.f */
common/vga_pkg.sv
hw/vga_timing.sv
hw/delay.sv
hw/draw_bg.sv
draw_health/sprite_rom.sv
draw_health/draw_health.sv
hw/game_top.sv
tb/game_top_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the overlay testbench with Verilator.
# Exits non-zero unless the simulation prints the pass line.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        -f sources.f --top-module game_top_tb -o game_top_sim; then
    echo "verilator build failed"
    exit 1
fi

output="$(./obj_dir/game_top_sim)"
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q -x -F ">>> PASS"; then
    exit 0
fi
exit 1

/* tb/game_top_tb.sv */
// self-checking testbench for the status overlay pipeline.
// checks every output pixel against a model of the timing, background and sprite rules.
`timescale 1ns/1ps
`default_nettype none

module game_top_tb;

    localparam int FRAME_LIMIT = 2 * 1056 * 628;   // cycles allowed per frame wait.
    localparam logic [11:0] C_BLANK  = 12'h888;
    localparam logic [11:0] C_BG     = 12'h135;
    localparam logic [11:0] C_BORDER = 12'hFFF;
    localparam logic [11:0] C_HEART  = 12'hF00;
    localparam logic [11:0] C_SHIELD = 12'h0AF;

    logic              clk = 1'b0;
    logic              rst;
    logic              game_en;
    logic              shielded;
    logic [2:0]        health;
    vga_pkg::vga_sig_t dut_vga;

    integer seed;
    string  test_name;
    int     test_errors;
    int     total_errors;
    int     tests_passed;
    int     tests_failed;
    int     live_cycles;
    int     prev_h;
    int     prev_v;
    logic   checking;
    logic   timed_out;

    game_top dut0 (
        .clk,
        .rst,
        .game_en,
        .shielded,
        .health,
        .vga(dut_vga)
    );

    always #20 clk = ~clk;

    task automatic note_value(input string what, input int expected, input int actual);
        test_errors++;
        total_errors++;
        if (test_errors <= 10) begin
            $display("FAIL %s: %s expected %0h actual %0h", test_name, what, expected, actual);
        end
    endtask

    task automatic end_test();
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d mismatches", test_name, test_errors);
        end
        test_errors = 0;
    endtask

    // colour by the background rule, then the sprite slots on top.
    function automatic logic [11:0] expected_rgb(input int hc, input int vc, input logic en,
                                                 input logic [2:0] hp, input logic sh);
        int          row;
        int          col;
        int          slot;
        logic [11:0] rgb;
        if (hc >= 800 || vc >= 600) begin
            return C_BLANK;
        end
        rgb = (hc == 0 || hc == 799 || vc == 0 || vc == 599) ? C_BORDER : C_BG;
        if (en && vc >= 16 && vc < 80) begin
            row = vc - 16;
            if (sh && hc >= 536 && hc < 600) begin
                col = hc - 536;   // shield frame is 4 pixels wide.
                if (row < 4 || row >= 60 || col < 4 || col >= 60) begin
                    rgb = C_SHIELD;
                end
            end else if (hc >= 600 && hc < 792) begin
                slot = (hc - 600) / 64;
                col = (hc - 600) % 64;
                if (hp[slot] && row >= 8 && row <= 55 && col >= 8 && col <= 55) begin
                    rgb = C_HEART;
                end
            end
        end
        return rgb;
    endfunction

    // inputs only change in vertical blanking, so the current levels hold for the frame.
    always @(negedge clk) begin : check_pixel
        int hc;
        int vc;
        int exp_h;
        int exp_v;
        if (rst) begin
            live_cycles = 0;
            checking = 1'b0;
        end else begin
            live_cycles = live_cycles + 1;
            hc = int'(dut_vga.hcount);
            vc = int'(dut_vga.vcount);
            if (checking) begin
                exp_h = (prev_h == 1055) ? 0 : prev_h + 1;
                exp_v = prev_v;
                if (prev_h == 1055) begin
                    exp_v = (prev_v == 627) ? 0 : prev_v + 1;   // next line after the wrap.
                end
                assert (hc == exp_h) else note_value("hcount step", exp_h, hc);
                assert (vc == exp_v) else note_value("vcount step", exp_v, vc);
                assert (dut_vga.hsync == (hc >= 840 && hc <= 967))
                    else note_value("hsync", int'(hc >= 840 && hc <= 967), int'(dut_vga.hsync));
                assert (dut_vga.hblnk == (hc >= 800))
                    else note_value("hblnk", int'(hc >= 800), int'(dut_vga.hblnk));
                assert (dut_vga.vblnk == (vc >= 600))
                    else note_value("vblnk", int'(vc >= 600), int'(dut_vga.vblnk));
                assert (dut_vga.rgb == expected_rgb(hc, vc, game_en, health, shielded))
                    else note_value("rgb", int'(expected_rgb(hc, vc, game_en, health, shielded)),
                                    int'(dut_vga.rgb));
            end
            prev_h = hc;
            prev_v = vc;
            checking = (live_cycles >= 6);   // pipeline is full by then.
        end
    end

    vsync_window: assert property (@(negedge clk) disable iff (!checking)
        dut_vga.vsync == (dut_vga.vcount >= 11'd601 && dut_vga.vcount <= 11'd604))
        else note_value("vsync", int'(dut_vga.vcount >= 11'd601 && dut_vga.vcount <= 11'd604),
                        int'(dut_vga.vsync));

    task automatic check_idle();
        assert ({dut_vga.hsync, dut_vga.vsync, dut_vga.hblnk, dut_vga.vblnk} == 4'b0000)
            else note_value("sync and blank", 0,
                            int'({dut_vga.hsync, dut_vga.vsync, dut_vga.hblnk, dut_vga.vblnk}));
        assert (dut_vga.rgb == 12'h000) else note_value("rgb", 0, int'(dut_vga.rgb));
    endtask

    // returns on the negedge where the output shows line 610, column 0.
    task automatic wait_frame();
        int waited;
        waited = 0;
        if (!timed_out) begin
            @(negedge clk);
            while (!(dut_vga.vcount == 11'd610 && dut_vga.hcount == 11'd0) &&
                   waited < FRAME_LIMIT) begin
                @(negedge clk);
                waited++;
            end
            if (waited >= FRAME_LIMIT) begin
                timed_out = 1'b1;
                $display("timeout in test %s: no frame boundary within %0d cycles",
                         test_name, FRAME_LIMIT);
            end
        end
    endtask

    task automatic next_status(input logic en, input logic sh, input logic random_health);
        game_en = en;
        shielded = sh;
        if (random_health) begin
            health = 3'($random(seed));
        end
    endtask

    initial begin
        seed = 22056;
        rst = 1'b1;
        game_en = 1'b0;
        shielded = 1'b0;
        health = 3'd0;
        test_errors = 0;
        total_errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        live_cycles = 0;
        prev_h = 0;
        prev_v = 0;
        checking = 1'b0;
        timed_out = 1'b0;

        test_name = "reset";
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            check_idle();
        end
        rst = 1'b0;
        @(negedge clk);
        check_idle();   // first cycle after release.
        end_test();

        test_name = "sync_timing";
        wait_frame();
        wait_frame();
        end_test();

        test_name = "background";
        next_status(1'b0, 1'($random(seed)), 1'b1);
        wait_frame();
        end_test();

        test_name = "hearts";
        for (int f = 0; f < 3; f++) begin
            next_status(1'b1, 1'b0, 1'b1);
            wait_frame();
        end
        end_test();

        test_name = "shield";
        next_status(1'b1, 1'b1, 1'b1);
        wait_frame();
        next_status(1'b1, 1'b0, 1'b1);
        wait_frame();
        end_test();

        test_name = "overlay_enable";
        health = 3'b111;
        next_status(1'b0, 1'b1, 1'b0);
        wait_frame();
        end_test();

        $display("tests: %0d passed, %0d failed, %0d mismatches",
                 tests_passed, tests_failed, total_errors);
        if (!timed_out && tests_failed == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hw/game_top.sv */
// status overlay pipeline: timing, background, then the health bar.
// output carries its own position, four clocks behind the counters.
`timescale 1ns/1ps
`default_nettype none

module game_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              game_en,
    input  logic              shielded,
    input  logic [2:0]        health,
    output vga_pkg::vga_sig_t vga
);

    import vga_pkg::*;

    vga_sig_t    timing_vga;
    vga_sig_t    bg_vga;
    logic [11:0] heart_addr;
    logic [11:0] shield_addr;
    logic [11:0] heart_texel;
    logic [11:0] shield_texel;

    vga_timing u_vga_timing (
        .clk,
        .rst,
        .vga(timing_vga)
    );

    draw_bg u_draw_bg (
        .clk,
        .rst,
        .in(timing_vga),
        .out(bg_vga)
    );

    draw_health u_draw_health (
        .clk,
        .rst,
        .game_en,
        .shielded,
        .health,
        .heart_texel,
        .shield_texel,
        .heart_addr,
        .shield_addr,
        .in(bg_vga),
        .out(vga)
    );

    sprite_rom #(.KIND(SPRITE_HEART)) u_heart_rom (
        .clk,
        .addr(heart_addr),
        .texel(heart_texel)
    );

    sprite_rom #(.KIND(SPRITE_SHIELD)) u_shield_rom (
        .clk,
        .addr(shield_addr),
        .texel(shield_texel)
    );

endmodule

`default_nettype wire

/* draw_health/draw_health.sv */
// health bar overlay: up to three hearts plus a shield to their left.
// three clocks of latency; addresses go out on the first, texels return on the second.
`timescale 1ns/1ps
`default_nettype none

module draw_health (
    input  logic              clk,
    input  logic              rst,
    input  logic              game_en,
    input  logic              shielded,
    input  logic [2:0]        health,
    input  logic [11:0]       heart_texel,
    input  logic [11:0]       shield_texel,
    output logic [11:0]       heart_addr,
    output logic [11:0]       shield_addr,
    input  vga_pkg::vga_sig_t in,
    output vga_pkg::vga_sig_t out
);

    import vga_pkg::*;

    vga_sig_t    dly;          // stream aligned with the rom outputs.
    logic        in_rows;
    logic        in_shield;
    logic        in_hearts;
    logic [10:0] heart_rel;
    logic [1:0]  heart_idx;
    logic        heart_on;
    logic        shield_on;
    logic [11:0] rgb_nxt;

    delay #(
        .DEPTH(2)
    ) u_delay (
        .clk,
        .rst,
        .din(in),
        .dout(dly)
    );

    // sprite addresses from the incoming position, row in the upper half.
    // column modulo 64 gives the offset inside whichever heart slot is hit.
    always_ff @(posedge clk) begin
        if (rst) begin
            heart_addr  <= '0;
            shield_addr <= '0;
        end else begin
            heart_addr  <= {6'(in.vcount - HEALTH_Y), 6'(in.hcount - HEALTH_X)};
            shield_addr <= {6'(in.vcount - HEALTH_Y), 6'(in.hcount - SHIELD_X)};
        end
    end

    // slot decode on the delayed position.
    assign in_rows   = (dly.vcount >= HEALTH_Y) && (dly.vcount < HEALTH_Y_END);
    assign in_shield = (dly.hcount >= SHIELD_X) && (dly.hcount < HEALTH_X);
    assign in_hearts = (dly.hcount >= HEALTH_X) && (dly.hcount < HEARTS_END);
    assign heart_rel = dly.hcount - HEALTH_X;
    assign heart_idx = heart_rel[7:6];   // which heart, valid only inside in_hearts.

    assign heart_on  = game_en && in_rows && in_hearts && health[heart_idx];
    assign shield_on = game_en && in_rows && in_shield && shielded;

    always_comb begin
        rgb_nxt = dly.rgb;
        if (dly.hblnk || dly.vblnk) begin
            rgb_nxt = dly.rgb;   // already blank colour from the background.
        end else if (shield_on && (shield_texel != TRANSPARENT_RGB)) begin
            rgb_nxt = shield_texel;
        end else if (heart_on && (heart_texel != TRANSPARENT_RGB)) begin
            rgb_nxt = heart_texel;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out <= '0;
        end else begin
            out     <= dly;
            out.rgb <= rgb_nxt;   // black texels leave the background visible.
        end
    end

endmodule

`default_nettype wire

/* draw_health/sprite_rom.sv */
// 64x64 sprite rom, one clock from address to texel.
// texels come from a geometric rule per sprite kind, so no memory file is needed.
`timescale 1ns/1ps
`default_nettype none

module sprite_rom #(
    parameter vga_pkg::sprite_kind_t KIND = vga_pkg::SPRITE_HEART
) (
    input  logic        clk,
    input  logic [11:0] addr,
    output logic [11:0] texel
);

    import vga_pkg::*;

    logic [5:0]  row;
    logic [5:0]  col;
    logic        hit;
    logic [11:0] ink;

    assign row = addr[11:6];
    assign col = addr[5:0];

    always_comb begin
        if (KIND == SPRITE_HEART) begin
            // solid inner square.
            hit = (row >= HEART_LO) && (row <= HEART_HI) &&
                  (col >= HEART_LO) && (col <= HEART_HI);
            ink = HEART_RGB;
        end else begin
            hit = (row < FRAME_LO) || (row >= FRAME_HI) ||
                  (col < FRAME_LO) || (col >= FRAME_HI);   // hollow frame.
            ink = SHIELD_RGB;
        end
    end

    always_ff @(posedge clk) begin
        texel <= hit ? ink : TRANSPARENT_RGB;
    end

endmodule

`default_nettype wire

/* hw/draw_bg.sv */
// background stage, one clock of latency.
// paints the play field, a one-pixel border and the blanking colour.
`timescale 1ns/1ps
`default_nettype none

module draw_bg (
    input  logic              clk,
    input  logic              rst,
    input  vga_pkg::vga_sig_t in,
    output vga_pkg::vga_sig_t out
);

    import vga_pkg::*;

    logic     on_border;
    vga_sig_t out_nxt;

    assign on_border = (in.hcount == 11'd0) || (in.hcount == H_ACTIVE - 11'd1) ||
                       (in.vcount == 11'd0) || (in.vcount == V_ACTIVE - 11'd1);

    always_comb begin
        out_nxt = in;   // timing fields pass straight through.
        if (in.hblnk || in.vblnk) begin
            out_nxt.rgb = BLANK_RGB;
        end else if (on_border) begin
            out_nxt.rgb = BORDER_RGB;
        end else begin
            out_nxt.rgb = BG_RGB;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out <= '0;
        end else begin
            out <= out_nxt;
        end
    end

endmodule

`default_nettype wire

/* hw/delay.sv */
// fixed-latency shift register for the pixel stream.
// keeps timing fields aligned with pipelined lookups elsewhere.
`timescale 1ns/1ps
`default_nettype none

module delay #(
    parameter int DEPTH = 1
) (
    input  logic              clk,
    input  logic              rst,
    input  vga_pkg::vga_sig_t din,
    output vga_pkg::vga_sig_t dout
);

    import vga_pkg::*;

    vga_sig_t stage [DEPTH];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= din;
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];   // shift one slot per clock.
            end
        end
    end

    assign dout = stage[DEPTH-1];

endmodule

`default_nettype wire

/* hw/vga_timing.sv */
// pixel and line counters for 800x600 at 40 MHz.
// drives position, sync and blanking at the head of the pipeline.
`timescale 1ns/1ps
`default_nettype none

module vga_timing (
    input  logic              clk,
    input  logic              rst,
    output vga_pkg::vga_sig_t vga
);

    import vga_pkg::*;

    logic        h_end;
    logic        v_end;
    logic [10:0] hcount_nxt;
    logic [10:0] vcount_nxt;

    assign h_end = (vga.hcount == H_TOTAL - 11'd1);
    assign v_end = (vga.vcount == V_TOTAL - 11'd1);

    always_comb begin
        hcount_nxt = h_end ? 11'd0 : vga.hcount + 11'd1;
        vcount_nxt = vga.vcount;
        if (h_end) begin
            vcount_nxt = v_end ? 11'd0 : vga.vcount + 11'd1;   // next line on wrap.
        end
    end

    // sync and blanking are derived from the next count so they stay aligned.
    always_ff @(posedge clk) begin
        if (rst) begin
            vga <= '0;
        end else begin
            vga.hcount <= hcount_nxt;
            vga.hsync  <= (hcount_nxt >= H_ACTIVE + H_FP) &&
                          (hcount_nxt <  H_ACTIVE + H_FP + H_SYNC);
            vga.hblnk  <= (hcount_nxt >= H_ACTIVE);
            vga.vcount <= vcount_nxt;
            vga.vsync  <= (vcount_nxt >= V_ACTIVE + V_FP) &&
                          (vcount_nxt <  V_ACTIVE + V_FP + V_SYNC);
            vga.vblnk  <= (vcount_nxt >= V_ACTIVE);
            vga.rgb    <= '0;   // colour is added downstream.
        end
    end

endmodule

`default_nettype wire

/* common/vga_pkg.sv */
// shared types and constants for the 800x600 status overlay pipeline.
// modules import this package in their bodies and use scoped names in port lists.
`default_nettype none

package vga_pkg;

    // horizontal timing, in pixels at 40 MHz.
    localparam logic [10:0] H_ACTIVE = 11'd800;
    localparam logic [10:0] H_FP     = 11'd40;
    localparam logic [10:0] H_SYNC   = 11'd128;
    localparam logic [10:0] H_TOTAL  = 11'd1056;

    // vertical timing, in lines.
    localparam logic [10:0] V_ACTIVE = 11'd600;
    localparam logic [10:0] V_FP     = 11'd1;
    localparam logic [10:0] V_SYNC   = 11'd4;
    localparam logic [10:0] V_TOTAL  = 11'd628;

    // health bar placement.
    localparam logic [10:0] SPRITE_SIZE  = 11'd64;
    localparam logic [10:0] HEALTH_X     = 11'd600;   // left edge of the first heart.
    localparam logic [10:0] HEALTH_Y     = 11'd16;
    localparam int          MAX_HEALTH   = 3;
    localparam logic [10:0] HEALTH_Y_END = HEALTH_Y + SPRITE_SIZE;
    localparam logic [10:0] SHIELD_X     = HEALTH_X - SPRITE_SIZE;   // shield sits left of hearts.
    localparam logic [10:0] HEARTS_END   = HEALTH_X + 11'(MAX_HEALTH) * SPRITE_SIZE;

    // texel rules, in sprite coordinates.
    localparam logic [5:0] HEART_LO = 6'd8;
    localparam logic [5:0] HEART_HI = 6'd55;
    localparam logic [5:0] FRAME_LO = 6'd4;    // frame covers rows/cols below this.
    localparam logic [5:0] FRAME_HI = 6'd60;   // ...and from this one up.

    // 12-bit rgb colours.
    localparam logic [11:0] BLANK_RGB       = 12'h888;
    localparam logic [11:0] BG_RGB          = 12'h135;
    localparam logic [11:0] BORDER_RGB      = 12'hFFF;
    localparam logic [11:0] HEART_RGB       = 12'hF00;
    localparam logic [11:0] SHIELD_RGB      = 12'h0AF;
    localparam logic [11:0] TRANSPARENT_RGB = 12'h000;

    // one pixel in flight, 38 bits.
    typedef struct packed {
        logic [10:0] hcount;
        logic        hsync;
        logic        hblnk;
        logic [10:0] vcount;
        logic        vsync;
        logic        vblnk;
        logic [11:0] rgb;
    } vga_sig_t;

    typedef enum logic {
        SPRITE_HEART,
        SPRITE_SHIELD
    } sprite_kind_t;

endpackage

`default_nettype wire
